//--- logic/cache_pkg.sv
package cache_pkg;

    // byte address and data word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // line geometry
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;

    // read moves a whole line
    // write moves one word
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

//--- logic/l1_cache.sv
module l1_cache
    import cache_pkg::*;
#(
    parameter int SETS = 8
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    input  mem_op_e           req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [WORD_W-1:0] req_wdata_i,
    output logic              resp_done_o,
    output logic [WORD_W-1:0] resp_rdata_o,
    output logic              mem_valid_o,
    output mem_op_e           mem_op_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o,
    input  logic              mem_done_i,
    input  logic [LINE_W-1:0] mem_rline_i,
    output logic              vc_lookup_valid_o,
    output logic [ADDR_W-1:0] vc_lookup_addr_o,
    output logic              vc_evict_valid_o,
    output logic [ADDR_W-1:0] vc_evict_tag_addr_o,
    output logic [LINE_W-1:0] vc_evict_line_o,
    output logic              vc_commit_o,
    input  logic              vc_hit_i,
    input  logic [LINE_W-1:0] vc_line_i
);

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - OFFSET_W - INDEX_W;
    localparam int WSEL_W  = $clog2(LINE_WORDS);

    typedef enum logic [2:0] {
        LOOKUP,
        VC_CHECK,
        FILL,
        WRITE_THROUGH,
        RESPOND
    } l1_state_e;

    l1_state_e state_q, state_d;

    // tag, line and valid arrays
    logic [TAG_W-1:0]  tag_q  [SETS];
    logic [LINE_W-1:0] line_q [SETS];
    logic [SETS-1:0]   valid_q;
    logic [WORD_W-1:0] rdata_q;

    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [WSEL_W-1:0]  wsel;
    logic               lookup_hit;
    logic               rd_hit;
    logic               wr_hit;
    logic               install;
    logic [LINE_W-1:0]  new_line;

    // address split
    assign idx  = req_addr_i[OFFSET_W +: INDEX_W];
    assign tag  = req_addr_i[ADDR_W-1 -: TAG_W];
    assign wsel = req_addr_i[2 +: WSEL_W];

    assign lookup_hit = valid_q[idx] && (tag_q[idx] == tag);
    assign rd_hit = (state_q == LOOKUP) && req_valid_i && (req_op_i == MEM_READ) && lookup_hit;
    assign wr_hit = (state_q == LOOKUP) && req_valid_i && (req_op_i == MEM_WRITE) && lookup_hit;

    // line arrives from a victim swap or a memory fill
    assign install  = ((state_q == VC_CHECK) && vc_hit_i) || ((state_q == FILL) && mem_done_i);
    assign new_line = (state_q == FILL) ? mem_rline_i : vc_line_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (req_valid_i) begin
                    if (req_op_i == MEM_WRITE) begin
                        state_d = WRITE_THROUGH;
                    end else if (lookup_hit) begin
                        state_d = RESPOND;
                    end else begin
                        state_d = VC_CHECK;
                    end
                end
            end
            // victim answers in this same cycle
            VC_CHECK:      state_d = vc_hit_i ? RESPOND : FILL;
            FILL:          state_d = mem_done_i ? RESPOND : FILL;
            WRITE_THROUGH: state_d = mem_done_i ? RESPOND : WRITE_THROUGH;
            RESPOND:       state_d = LOOKUP;
            default:       state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= LOOKUP;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (install) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    // payload side of the arrays
    always_ff @(posedge clk_i) begin
        if (install) begin
            line_q[idx] <= new_line;
            tag_q[idx]  <= tag;
            rdata_q     <= new_line[wsel*WORD_W +: WORD_W];
        end else if (wr_hit) begin
            line_q[idx][wsel*WORD_W +: WORD_W] <= req_wdata_i;
        end else if (rd_hit) begin
            rdata_q <= line_q[idx][wsel*WORD_W +: WORD_W];
        end
    end

    assign resp_done_o  = (state_q == RESPOND);
    assign resp_rdata_o = rdata_q;

    // memory side, read fills a line and write goes through
    assign mem_valid_o = (state_q == FILL) || (state_q == WRITE_THROUGH);
    assign mem_op_o    = (state_q == WRITE_THROUGH) ? MEM_WRITE : MEM_READ;
    assign mem_addr_o  = req_addr_i;
    assign mem_wdata_o = req_wdata_i;

    // a write keeps invalidating any victim copy while it waits on memory
    assign vc_lookup_valid_o   = (state_q == VC_CHECK) || (state_q == WRITE_THROUGH);
    assign vc_lookup_addr_o    = req_addr_i;
    assign vc_evict_valid_o    = (state_q == VC_CHECK) && valid_q[idx];
    assign vc_evict_tag_addr_o = {tag_q[idx], idx, {OFFSET_W{1'b0}}};
    assign vc_evict_line_o     = line_q[idx];
    assign vc_commit_o         = vc_lookup_valid_o;

    // done only against a request still held by the cpu
    assert property (@(posedge clk_i) disable iff (!rst_ni) resp_done_o |-> req_valid_i);

endmodule

//--- logic/victim_cache.sv
module victim_cache
    import cache_pkg::*;
#(
    parameter int VC_ENTRIES = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              lookup_valid_i,
    input  logic [ADDR_W-1:0] lookup_addr_i,
    input  logic              evict_valid_i,
    input  logic [ADDR_W-1:0] evict_tag_addr_i,
    input  logic [LINE_W-1:0] evict_line_i,
    input  logic              commit_i,
    output logic              hit_o,
    output logic [LINE_W-1:0] line_o
);

    localparam int LADDR_W = ADDR_W - OFFSET_W;
    localparam int PTR_W   = (VC_ENTRIES > 1) ? $clog2(VC_ENTRIES) : 1;

    // entries hold full line addresses
    logic [LADDR_W-1:0]    tag_q  [VC_ENTRIES];
    logic [LINE_W-1:0]     line_q [VC_ENTRIES];
    logic [VC_ENTRIES-1:0] valid_q;
    logic [PTR_W-1:0]      rr_q;

    logic [VC_ENTRIES-1:0] hit_vec;
    logic [VC_ENTRIES-1:0] ev_vec;
    logic [PTR_W-1:0]      hit_idx;
    logic [PTR_W-1:0]      ev_idx;
    logic [PTR_W-1:0]      ins_idx;
    logic                  hit;

    // compare against every entry
    always_comb begin
        hit_vec = '0;
        ev_vec  = '0;
        hit_idx = '0;
        ev_idx  = '0;
        for (int e = 0; e < VC_ENTRIES; e++) begin
            hit_vec[e] = valid_q[e] && (tag_q[e] == lookup_addr_i[ADDR_W-1:OFFSET_W]);
            ev_vec[e]  = valid_q[e] && (tag_q[e] == evict_tag_addr_i[ADDR_W-1:OFFSET_W]);
            if (hit_vec[e]) begin
                hit_idx = PTR_W'(e);
            end
            if (ev_vec[e]) begin
                ev_idx = PTR_W'(e);
            end
        end
    end

    assign hit    = lookup_valid_i && (|hit_vec);
    assign hit_o  = hit;
    assign line_o = hit ? line_q[hit_idx] : '0;

    // other L1 may have parked the same line already
    // then its slot is reused, else the swapped slot, else round robin
    always_comb begin
        if (|ev_vec) begin
            ins_idx = ev_idx;
        end else if (hit) begin
            ins_idx = hit_idx;
        end else begin
            ins_idx = rr_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (commit_i && evict_valid_i) begin
            tag_q[ins_idx]  <= evict_tag_addr_i[ADDR_W-1:OFFSET_W];
            line_q[ins_idx] <= evict_line_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (commit_i) begin
            // hit entry leaves, refilled below on a swap
            if (hit) begin
                valid_q[hit_idx] <= 1'b0;
            end
            if (evict_valid_i) begin
                valid_q[ins_idx] <= 1'b1;
                if (!(|ev_vec) && !hit) begin
                    rr_q <= (rr_q == PTR_W'(VC_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
                end
            end
        end
    end

    // insert policy keeps each line address unique
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_vec));

endmodule

//--- logic/cache_arbiter.sv
module cache_arbiter
    import cache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              i_mem_valid_i,
    input  mem_op_e           i_mem_op_i,
    input  logic [ADDR_W-1:0] i_mem_addr_i,
    input  logic [WORD_W-1:0] i_mem_wdata_i,
    input  logic              i_vc_lookup_valid_i,
    input  logic [ADDR_W-1:0] i_vc_lookup_addr_i,
    input  logic              i_vc_evict_valid_i,
    input  logic [ADDR_W-1:0] i_vc_evict_tag_addr_i,
    input  logic [LINE_W-1:0] i_vc_evict_line_i,
    input  logic              i_vc_commit_i,
    input  logic              d_mem_valid_i,
    input  mem_op_e           d_mem_op_i,
    input  logic [ADDR_W-1:0] d_mem_addr_i,
    input  logic [WORD_W-1:0] d_mem_wdata_i,
    input  logic              d_vc_lookup_valid_i,
    input  logic [ADDR_W-1:0] d_vc_lookup_addr_i,
    input  logic              d_vc_evict_valid_i,
    input  logic [ADDR_W-1:0] d_vc_evict_tag_addr_i,
    input  logic [LINE_W-1:0] d_vc_evict_line_i,
    input  logic              d_vc_commit_i,
    input  logic              mem_done_i,
    input  logic [LINE_W-1:0] mem_rline_i,
    input  logic              vc_hit_i,
    input  logic [LINE_W-1:0] vc_line_i,
    output logic              i_mem_done_o,
    output logic [LINE_W-1:0] i_mem_rline_o,
    output logic              i_vc_hit_o,
    output logic [LINE_W-1:0] i_vc_line_o,
    output logic              d_mem_done_o,
    output logic [LINE_W-1:0] d_mem_rline_o,
    output logic              d_vc_hit_o,
    output logic [LINE_W-1:0] d_vc_line_o,
    output logic              mem_valid_o,
    output mem_op_e           mem_op_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o,
    output logic              vc_lookup_valid_o,
    output logic [ADDR_W-1:0] vc_lookup_addr_o,
    output logic              vc_evict_valid_o,
    output logic [ADDR_W-1:0] vc_evict_tag_addr_o,
    output logic [LINE_W-1:0] vc_evict_line_o,
    output logic              vc_commit_o
);

    typedef enum logic [1:0] {
        IDLE,
        I_CACHE,
        D_CACHE
    } owner_e;

    owner_e            state_q, state_d;
    mem_op_e           owner_op;
    logic [ADDR_W-1:0] owner_addr;
    logic              vc_sel_icache;

    // owner holds until its valid drops, icache wins from idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_mem_valid_i) begin
                    state_d = I_CACHE;
                end else if (d_mem_valid_i) begin
                    state_d = D_CACHE;
                end
            end
            I_CACHE: begin
                if (!i_mem_valid_i) begin
                    state_d = d_mem_valid_i ? D_CACHE : IDLE;
                end
            end
            D_CACHE: begin
                if (!d_mem_valid_i) begin
                    state_d = i_mem_valid_i ? I_CACHE : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // pass owner request through, results to owner only
    always_comb begin
        mem_valid_o   = 1'b0;
        owner_op      = MEM_READ;
        owner_addr    = '0;
        mem_wdata_o   = '0;
        i_mem_done_o  = 1'b0;
        i_mem_rline_o = '0;
        d_mem_done_o  = 1'b0;
        d_mem_rline_o = '0;
        case (state_q)
            I_CACHE: begin
                mem_valid_o   = i_mem_valid_i;
                owner_op      = i_mem_op_i;
                owner_addr    = i_mem_addr_i;
                mem_wdata_o   = i_mem_wdata_i;
                i_mem_done_o  = mem_done_i;
                i_mem_rline_o = mem_rline_i;
            end
            D_CACHE: begin
                mem_valid_o   = d_mem_valid_i;
                owner_op      = d_mem_op_i;
                owner_addr    = d_mem_addr_i;
                mem_wdata_o   = d_mem_wdata_i;
                d_mem_done_o  = mem_done_i;
                d_mem_rline_o = mem_rline_i;
            end
            default: begin
            end
        endcase
    end

    // line reads start at word 0
    assign mem_op_o   = owner_op;
    assign mem_addr_o = (owner_op == MEM_READ) ?
                        {owner_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} : owner_addr;

    // victim path, icache first
    assign vc_sel_icache       = i_vc_lookup_valid_i;
    assign vc_lookup_valid_o   = i_vc_lookup_valid_i || d_vc_lookup_valid_i;
    assign vc_lookup_addr_o    = vc_sel_icache ? i_vc_lookup_addr_i : d_vc_lookup_addr_i;
    assign vc_evict_valid_o    = vc_sel_icache ? i_vc_evict_valid_i : d_vc_evict_valid_i;
    assign vc_evict_tag_addr_o = vc_sel_icache ? i_vc_evict_tag_addr_i : d_vc_evict_tag_addr_i;
    assign vc_evict_line_o     = vc_sel_icache ? i_vc_evict_line_i : d_vc_evict_line_i;
    assign vc_commit_o         = vc_sel_icache ? i_vc_commit_i : d_vc_commit_i;
    assign i_vc_hit_o          = vc_sel_icache && vc_hit_i;
    assign i_vc_line_o         = vc_sel_icache ? vc_line_i : '0;
    assign d_vc_hit_o          = !vc_sel_icache && vc_hit_i;
    assign d_vc_line_o         = vc_sel_icache ? '0 : vc_line_i;

    // no handover under a live request
    // memory keeps seeing the same request until its done
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_valid_o && !mem_done_i) |=>
        (mem_valid_o && $stable(mem_op_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)));

endmodule

//--- logic/backing_mem.sv
module backing_mem
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              valid_i,
    input  mem_op_e           op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic              done_o,
    output logic [LINE_W-1:0] rline_o
);

    localparam int WADDR_W = $clog2(MEM_WORDS);
    localparam int WSEL_W  = $clog2(LINE_WORDS);
    localparam int CNT_W   = $clog2(MEM_LATENCY + 1);

    logic [WORD_W-1:0]  mem_q [MEM_WORDS];
    logic               busy_q;
    logic               wait_low_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [WADDR_W-1:0] waddr;
    logic               finish;

    // word index from byte address
    assign waddr  = addr_i[2 +: WADDR_W];
    assign finish = busy_q && (cnt_q == CNT_W'(MEM_LATENCY - 1));
    assign done_o = finish;

    // whole line around the word index
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            rline_o[w*WORD_W +: WORD_W] = mem_q[{waddr[WADDR_W-1:WSEL_W], WSEL_W'(w)}];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            wait_low_q <= 1'b0;
            cnt_q      <= '0;
            for (int k = 0; k < MEM_WORDS; k++) begin
                mem_q[k] <= WORD_W'(k) ^ 32'hA5A5_0000;
            end
        end else begin
            // rearm once the requester lets go
            if (!valid_i) begin
                wait_low_q <= 1'b0;
            end
            if (finish) begin
                busy_q     <= 1'b0;
                wait_low_q <= 1'b1;
                if (op_i == MEM_WRITE) begin
                    mem_q[waddr] <= wdata_i;
                end
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (valid_i && !wait_low_q) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end
    end

endmodule

//--- logic/cache_subsystem.sv
module cache_subsystem
    import cache_pkg::*;
#(
    parameter int SETS        = 8,
    parameter int VC_ENTRIES  = 4,
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              if_req_valid_i,
    input  logic [ADDR_W-1:0] if_req_addr_i,
    output logic              if_resp_done_o,
    output logic [WORD_W-1:0] if_resp_rdata_o,
    input  logic              ls_req_valid_i,
    input  mem_op_e           ls_req_op_i,
    input  logic [ADDR_W-1:0] ls_req_addr_i,
    input  logic [WORD_W-1:0] ls_req_wdata_i,
    output logic              ls_resp_done_o,
    output logic [WORD_W-1:0] ls_resp_rdata_o
);

    // icache and dcache to arbiter
    logic              ic_mem_valid, ic_mem_done, ic_vc_lookup_valid, ic_vc_evict_valid;
    logic              ic_vc_commit, ic_vc_hit;
    mem_op_e           ic_mem_op;
    logic [ADDR_W-1:0] ic_mem_addr, ic_vc_lookup_addr, ic_vc_evict_tag_addr;
    logic [WORD_W-1:0] ic_mem_wdata;
    logic [LINE_W-1:0] ic_mem_rline, ic_vc_evict_line, ic_vc_line;
    logic              dc_mem_valid, dc_mem_done, dc_vc_lookup_valid, dc_vc_evict_valid;
    logic              dc_vc_commit, dc_vc_hit;
    mem_op_e           dc_mem_op;
    logic [ADDR_W-1:0] dc_mem_addr, dc_vc_lookup_addr, dc_vc_evict_tag_addr;
    logic [WORD_W-1:0] dc_mem_wdata;
    logic [LINE_W-1:0] dc_mem_rline, dc_vc_evict_line, dc_vc_line;

    // arbiter to memory and victim cache
    logic              mem_valid, mem_done, vc_lookup_valid, vc_evict_valid, vc_commit, vc_hit;
    mem_op_e           mem_op;
    logic [ADDR_W-1:0] mem_addr, vc_lookup_addr, vc_evict_tag_addr;
    logic [WORD_W-1:0] mem_wdata;
    logic [LINE_W-1:0] mem_rline, vc_evict_line, vc_line;

    // fetch port reads only
    l1_cache #(.SETS(SETS)) u_icache (
        .clk_i, .rst_ni,
        .req_valid_i(if_req_valid_i), .req_op_i(MEM_READ),
        .req_addr_i(if_req_addr_i), .req_wdata_i('0),
        .resp_done_o(if_resp_done_o), .resp_rdata_o(if_resp_rdata_o),
        .mem_valid_o(ic_mem_valid), .mem_op_o(ic_mem_op),
        .mem_addr_o(ic_mem_addr), .mem_wdata_o(ic_mem_wdata),
        .mem_done_i(ic_mem_done), .mem_rline_i(ic_mem_rline),
        .vc_lookup_valid_o(ic_vc_lookup_valid), .vc_lookup_addr_o(ic_vc_lookup_addr),
        .vc_evict_valid_o(ic_vc_evict_valid), .vc_evict_tag_addr_o(ic_vc_evict_tag_addr),
        .vc_evict_line_o(ic_vc_evict_line), .vc_commit_o(ic_vc_commit),
        .vc_hit_i(ic_vc_hit), .vc_line_i(ic_vc_line)
    );

    l1_cache #(.SETS(SETS)) u_dcache (
        .clk_i, .rst_ni,
        .req_valid_i(ls_req_valid_i), .req_op_i(ls_req_op_i),
        .req_addr_i(ls_req_addr_i), .req_wdata_i(ls_req_wdata_i),
        .resp_done_o(ls_resp_done_o), .resp_rdata_o(ls_resp_rdata_o),
        .mem_valid_o(dc_mem_valid), .mem_op_o(dc_mem_op),
        .mem_addr_o(dc_mem_addr), .mem_wdata_o(dc_mem_wdata),
        .mem_done_i(dc_mem_done), .mem_rline_i(dc_mem_rline),
        .vc_lookup_valid_o(dc_vc_lookup_valid), .vc_lookup_addr_o(dc_vc_lookup_addr),
        .vc_evict_valid_o(dc_vc_evict_valid), .vc_evict_tag_addr_o(dc_vc_evict_tag_addr),
        .vc_evict_line_o(dc_vc_evict_line), .vc_commit_o(dc_vc_commit),
        .vc_hit_i(dc_vc_hit), .vc_line_i(dc_vc_line)
    );

    cache_arbiter u_arbiter (
        .clk_i, .rst_ni,
        .i_mem_valid_i(ic_mem_valid), .i_mem_op_i(ic_mem_op),
        .i_mem_addr_i(ic_mem_addr), .i_mem_wdata_i(ic_mem_wdata),
        .i_vc_lookup_valid_i(ic_vc_lookup_valid), .i_vc_lookup_addr_i(ic_vc_lookup_addr),
        .i_vc_evict_valid_i(ic_vc_evict_valid), .i_vc_evict_tag_addr_i(ic_vc_evict_tag_addr),
        .i_vc_evict_line_i(ic_vc_evict_line), .i_vc_commit_i(ic_vc_commit),
        .d_mem_valid_i(dc_mem_valid), .d_mem_op_i(dc_mem_op),
        .d_mem_addr_i(dc_mem_addr), .d_mem_wdata_i(dc_mem_wdata),
        .d_vc_lookup_valid_i(dc_vc_lookup_valid), .d_vc_lookup_addr_i(dc_vc_lookup_addr),
        .d_vc_evict_valid_i(dc_vc_evict_valid), .d_vc_evict_tag_addr_i(dc_vc_evict_tag_addr),
        .d_vc_evict_line_i(dc_vc_evict_line), .d_vc_commit_i(dc_vc_commit),
        .mem_done_i(mem_done), .mem_rline_i(mem_rline),
        .vc_hit_i(vc_hit), .vc_line_i(vc_line),
        .i_mem_done_o(ic_mem_done), .i_mem_rline_o(ic_mem_rline),
        .i_vc_hit_o(ic_vc_hit), .i_vc_line_o(ic_vc_line),
        .d_mem_done_o(dc_mem_done), .d_mem_rline_o(dc_mem_rline),
        .d_vc_hit_o(dc_vc_hit), .d_vc_line_o(dc_vc_line),
        .mem_valid_o(mem_valid), .mem_op_o(mem_op),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .vc_lookup_valid_o(vc_lookup_valid), .vc_lookup_addr_o(vc_lookup_addr),
        .vc_evict_valid_o(vc_evict_valid), .vc_evict_tag_addr_o(vc_evict_tag_addr),
        .vc_evict_line_o(vc_evict_line), .vc_commit_o(vc_commit)
    );

    victim_cache #(.VC_ENTRIES(VC_ENTRIES)) u_victim (
        .clk_i, .rst_ni,
        .lookup_valid_i(vc_lookup_valid), .lookup_addr_i(vc_lookup_addr),
        .evict_valid_i(vc_evict_valid), .evict_tag_addr_i(vc_evict_tag_addr),
        .evict_line_i(vc_evict_line), .commit_i(vc_commit),
        .hit_o(vc_hit), .line_o(vc_line)
    );

    backing_mem #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) u_mem (
        .clk_i, .rst_ni,
        .valid_i(mem_valid), .op_i(mem_op), .addr_i(mem_addr), .wdata_i(mem_wdata),
        .done_o(mem_done), .rline_o(mem_rline)
    );

endmodule

//--- verification/cache_subsystem_tb.sv
module cache_subsystem_tb
    import cache_pkg::*;
;

    localparam int TB_SETS        = 4;
    localparam int TB_VC_ENTRIES  = 2;
    localparam int TB_MEM_LATENCY = 4;
    localparam int TB_MEM_WORDS   = 1024;
    localparam int CLK_PERIOD     = 40;

    // requests issued over all tests, summed by hand
    localparam int NUM_REQUESTS    = 5 + 3 + 4 + 2 + 40;
    localparam int REQ_CYCLES      = 2 * TB_MEM_LATENCY + 20;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * REQ_CYCLES + 4 + 10;
    // one request never needs more than this
    localparam int REQ_TIMEOUT     = 4 * REQ_CYCLES;

    logic              clk_i;
    logic              rst_ni;
    logic              if_req_valid_i;
    logic [ADDR_W-1:0] if_req_addr_i;
    logic              if_resp_done_o;
    logic [WORD_W-1:0] if_resp_rdata_o;
    logic              ls_req_valid_i;
    mem_op_e           ls_req_op_i;
    logic [ADDR_W-1:0] ls_req_addr_i;
    logic [WORD_W-1:0] ls_req_wdata_i;
    logic              ls_resp_done_o;
    logic [WORD_W-1:0] ls_resp_rdata_o;

    // expected memory image
    logic [WORD_W-1:0] model_mem [TB_MEM_WORDS];

    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    int seed;

    cache_subsystem #(
        .SETS(TB_SETS),
        .VC_ENTRIES(TB_VC_ENTRIES),
        .MEM_LATENCY(TB_MEM_LATENCY),
        .MEM_WORDS(TB_MEM_WORDS)
    ) u_cache_subsystem (
        .clk_i, .rst_ni,
        .if_req_valid_i, .if_req_addr_i, .if_resp_done_o, .if_resp_rdata_o,
        .ls_req_valid_i, .ls_req_op_i, .ls_req_addr_i, .ls_req_wdata_i,
        .ls_resp_done_o, .ls_resp_rdata_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // hard stop if a handshake never closes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // initial content of word k
    function automatic logic [WORD_W-1:0] rule_word(input int k);
        return WORD_W'(k) ^ 32'hA5A5_0000;
    endfunction

    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[ADDR_W-1:2]) % TB_MEM_WORDS;
    endfunction

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_done(input string what, input logic seen);
        check_count++;
        if (seen !== 1'b1) begin
            error_count++;
            $display("no completion for %s within %0d cycles at time %0t",
                     what, REQ_TIMEOUT, $time);
        end
    endtask

    // one handshake on either port, valid held until done
    task automatic do_request(input bit is_data, input mem_op_e op,
                              input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                              output logic [WORD_W-1:0] rdata, output logic done_seen);
        int waited;
        @(posedge clk_i);
        #2;
        if (is_data) begin
            ls_req_valid_i = 1'b1;
            ls_req_op_i    = op;
            ls_req_addr_i  = addr;
            ls_req_wdata_i = wdata;
        end else begin
            if_req_valid_i = 1'b1;
            if_req_addr_i  = addr;
        end
        done_seen = 1'b0;
        rdata     = '0;
        waited    = 0;
        // outputs settle well before the falling edge
        while (!done_seen && waited < REQ_TIMEOUT) begin
            @(negedge clk_i);
            done_seen = is_data ? ls_resp_done_o : if_resp_done_o;
            rdata     = is_data ? ls_resp_rdata_o : if_resp_rdata_o;
            waited++;
        end
        @(posedge clk_i);
        #2;
        if (is_data) begin
            ls_req_valid_i = 1'b0;
        end else begin
            if_req_valid_i = 1'b0;
        end
    endtask

    task automatic read_check(input bit is_data, input logic [ADDR_W-1:0] addr,
                              input string name);
        logic [WORD_W-1:0] rdata;
        logic              seen;
        do_request(is_data, MEM_READ, addr, '0, rdata, seen);
        check_done(name, seen);
        if (seen) begin
            check_word(name, rdata, model_mem[word_index(addr)]);
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                              input string name);
        logic [WORD_W-1:0] rdata;
        logic              seen;
        do_request(1'b1, MEM_WRITE, addr, data, rdata, seen);
        check_done(name, seen);
        model_mem[word_index(addr)] = data;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            failed_tests++;
            $display("test %-12s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = error_count;
        repeat (10) begin
            @(negedge clk_i);
            check_word("if_resp_done_o", WORD_W'(if_resp_done_o), '0);
            check_word("ls_resp_done_o", WORD_W'(ls_resp_done_o), '0);
        end
        finish_test("reset", errs);
    endtask

    // miss, hit, then rest of the filled line
    task automatic test_icache_read();
        int errs;
        errs = error_count;
        read_check(1'b0, 32'h040, "if_resp_rdata_o");
        read_check(1'b0, 32'h040, "if_resp_rdata_o");
        read_check(1'b0, 32'h044, "if_resp_rdata_o");
        read_check(1'b0, 32'h048, "if_resp_rdata_o");
        read_check(1'b0, 32'h04C, "if_resp_rdata_o");
        finish_test("icache_read", errs);
    endtask

    task automatic test_store_load();
        int errs;
        errs = error_count;
        write_word(32'h208, 32'hDEAD_BEEF, "ls_resp_done_o");
        read_check(1'b1, 32'h208, "ls_resp_rdata_o");
        read_check(1'b1, 32'h20C, "ls_resp_rdata_o");
        finish_test("store_load", errs);
    endtask

    // same set twice, second pass comes back via the victim cache
    task automatic test_victim_swap();
        int errs;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        errs = error_count;
        a = 32'h104;
        b = a + ADDR_W'(TB_SETS * 16);
        read_check(1'b1, a, "ls_resp_rdata_o");
        read_check(1'b1, b, "ls_resp_rdata_o");
        read_check(1'b1, a, "ls_resp_rdata_o");
        read_check(1'b1, b, "ls_resp_rdata_o");
        finish_test("victim_swap", errs);
    endtask

    // both ports miss in the same cycle
    task automatic test_contention();
        int errs;
        logic [WORD_W-1:0] i_data;
        logic [WORD_W-1:0] d_data;
        logic              i_seen;
        logic              d_seen;
        errs = error_count;
        fork
            do_request(1'b0, MEM_READ, 32'h300, '0, i_data, i_seen);
            do_request(1'b1, MEM_READ, 32'h384, '0, d_data, d_seen);
        join
        check_done("instruction read", i_seen);
        check_done("data read", d_seen);
        check_word("if_resp_rdata_o", i_data, model_mem[word_index(32'h300)]);
        check_word("ls_resp_rdata_o", d_data, model_mem[word_index(32'h384)]);
        finish_test("contention", errs);
    endtask

    // fetches and data kept in separate regions, no coherence between L1s
    task automatic test_random_traffic();
        int errs;
        logic [31:0]       r;
        logic [31:0]       w;
        logic [ADDR_W-1:0] addr;
        errs = error_count;
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            w = $random(seed);
            case (r[9:8])
                2'd0, 2'd1: begin
                    addr = 32'h000 + (ADDR_W'(r[5:0]) << 2);
                    read_check(1'b0, addr, "if_resp_rdata_o");
                end
                2'd2: begin
                    addr = 32'h200 + (ADDR_W'(r[5:0]) << 2);
                    read_check(1'b1, addr, "ls_resp_rdata_o");
                end
                default: begin
                    addr = 32'h200 + (ADDR_W'(r[5:0]) << 2);
                    write_word(addr, w, "ls_resp_done_o");
                end
            endcase
        end
        finish_test("random", errs);
    endtask

    initial begin
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        seed           = 32'h4481_87f7;
        rst_ni         = 1'b0;
        if_req_valid_i = 1'b0;
        if_req_addr_i  = '0;
        ls_req_valid_i = 1'b0;
        ls_req_op_i    = MEM_READ;
        ls_req_addr_i  = '0;
        ls_req_wdata_i = '0;
        for (int k = 0; k < TB_MEM_WORDS; k++) begin
            model_mem[k] = rule_word(k);
        end
        repeat (4) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        test_reset();
        test_icache_read();
        test_store_load();
        test_victim_swap();
        test_contention();
        test_random_traffic();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
logic/cache_pkg.sv
logic/l1_cache.sv
logic/victim_cache.sv
logic/cache_arbiter.sv
logic/backing_mem.sv
logic/cache_subsystem.sv
verification/cache_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_subsystem_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
